/* hdl/photon_pkg.sv */
package photon_pkg;

    //////////////////////////////
    // Memory geometry.
    //////////////////////////////
    localparam int ADDR_W = 24;       // Bank(2)+Row(13)+Column(9).
    localparam int DATA_W = 16;       // One memory word.
    localparam int COUNT_W = 32;      // Photon count per sync period.

    localparam int FRAME_WORDS = 8;   // One word per hex digit.
    localparam int WORD_IDX_W = $clog2(FRAME_WORDS);
    localparam logic [WORD_IDX_W-1:0] LAST_WORD = WORD_IDX_W'(FRAME_WORDS - 1);
    localparam logic [ADDR_W-1:0] FRAME_BASE = 24'h000100;

    // Behavioural memory model.
    localparam int MEM_LATENCY = 4;   // Accept to done, in cycles.
    localparam int LAT_W = $clog2(MEM_LATENCY);
    localparam logic [LAT_W-1:0] LAT_LAST = LAT_W'(MEM_LATENCY - 1);
    localparam int MEM_DEPTH = 16;    // Only low address bits decoded.
    localparam int MEM_IDX_W = $clog2(MEM_DEPTH);

    //////////////////////////////
    // Memory port bundles.
    //////////////////////////////
    // Request side, held until done.
    typedef struct packed {
        logic              rd;
        logic              wr;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;   // Write data.
    } mem_cmd_t;

    // Response side.
    typedef struct packed {
        logic              done;   // One-cycle pulse.
        logic [DATA_W-1:0] data;   // Read data, valid with done.
    } mem_rsp_t;

    //////////////////////////////
    // State encodings.
    //////////////////////////////
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WRITE,
        ARB_READ
    } arb_owner_t;

    typedef enum logic [1:0] {
        DRAW_IDLE,
        DRAW_REQ,
        DRAW_NEXT
    } draw_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_REQ,
        RD_SHOW
    } read_state_t;

endpackage

/* hdl/pulse_counter.sv */
`timescale 1ns/1ps

module pulse_counter (
    input  logic                          clk_133MHz_210,
    input  logic                          rst_n,
    input  logic                          photon_pulse,   // Async pin.
    input  logic                          sync_50Hz,      // Async pin.
    output logic                          count_update,   // One-cycle pulse.
    output logic [photon_pkg::COUNT_W-1:0] count          // Last period total.
);

    //////////////////////////////
    // Input synchronisers.
    //////////////////////////////
    logic [1:0] photon_sync;   // Two flops per input.
    logic [1:0] sync_sync;
    logic       photon_d;      // Delayed copy for edge detect.
    logic       sync_d;
    logic       photon_rise;
    logic       sync_rise;

    logic [photon_pkg::COUNT_W-1:0] running;   // Count in current period.

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            photon_sync <= '0;
            sync_sync   <= '0;
            photon_d    <= 1'b0;
            sync_d      <= 1'b0;
        end else begin
            photon_sync <= {photon_sync[0], photon_pulse};
            sync_sync   <= {sync_sync[0], sync_50Hz};
            photon_d    <= photon_sync[1];
            sync_d      <= sync_sync[1];
        end
    end

    // Rising edges, one cycle wide.
    assign photon_rise = photon_sync[1] & ~photon_d;
    assign sync_rise   = sync_sync[1] & ~sync_d;

    //////////////////////////////
    // Period counter.
    //////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            running      <= '0;
            count        <= '0;
            count_update <= 1'b0;
        end else begin
            count_update <= 1'b0;
            if (sync_rise) begin
                // Publish the period total.
                count        <= running;
                count_update <= 1'b1;
                // A coincident photon edge opens the new period.
                running      <= photon_rise ? photon_pkg::COUNT_W'(1) : '0;
            end else if (photon_rise && (running != '1)) begin
                running <= running + 1'b1;   // Saturates at all ones.
            end
        end
    end

endmodule

/* hdl/draw_writer.sv */
`timescale 1ns/1ps

module draw_writer (
    input  logic                           clk_133MHz_210,
    input  logic                           rst_n,
    input  logic                           count_update,
    input  logic [photon_pkg::COUNT_W-1:0] count,
    output photon_pkg::mem_cmd_t           wr_cmd,
    input  logic                           wr_done,
    output logic                           frame_ready   // After last write.
);

    photon_pkg::draw_state_t state;

    logic [photon_pkg::COUNT_W-1:0]    value;       // Count being drawn.
    logic [photon_pkg::WORD_IDX_W-1:0] digit;       // Nibble index, 7 down to 0.
    logic                              pend;        // Update seen mid-draw.
    logic [photon_pkg::COUNT_W-1:0]    pend_value;  // Latest one wins.

    // Hex nibble to ASCII character word.
    function automatic logic [photon_pkg::DATA_W-1:0] hex_char(input logic [3:0] nib);
        logic [7:0]                    ascii;
        logic [photon_pkg::DATA_W-1:0] word;
        ascii = (nib < 4'd10) ? (8'h30 + {4'h0, nib}) : (8'h37 + {4'h0, nib});
        word = '0;
        word[7:0] = ascii;   // Zero extended.
        return word;
    endfunction

    //////////////////////////////
    // Write request.
    //////////////////////////////
    always_comb begin
        wr_cmd      = '0;
        wr_cmd.wr   = (state == photon_pkg::DRAW_REQ);   // Held until done.
        // MS nibble lands at FRAME_BASE+0.
        wr_cmd.addr = photon_pkg::FRAME_BASE
                    + {{(photon_pkg::ADDR_W - photon_pkg::WORD_IDX_W){1'b0}}, ~digit};
        wr_cmd.data = hex_char(value[{digit, 2'b00} +: 4]);
    end

    //////////////////////////////
    // Draw FSM.
    //////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state       <= photon_pkg::DRAW_IDLE;
            digit       <= '0;
            pend        <= 1'b0;
            frame_ready <= 1'b0;
        end else begin
            frame_ready <= 1'b0;
            // Keep one update in reserve while busy.
            if (count_update && (state != photon_pkg::DRAW_IDLE)) begin
                pend       <= 1'b1;
                pend_value <= count;
            end
            case (state)
                photon_pkg::DRAW_IDLE: begin
                    if (count_update || pend) begin
                        value <= count_update ? count : pend_value;   // Newest first.
                        pend  <= 1'b0;
                        digit <= photon_pkg::LAST_WORD;
                        state <= photon_pkg::DRAW_REQ;
                    end
                end
                photon_pkg::DRAW_REQ: begin
                    if (wr_done) state <= photon_pkg::DRAW_NEXT;   // Request drops next.
                end
                photon_pkg::DRAW_NEXT: begin
                    if (digit == '0) begin
                        frame_ready <= 1'b1;   // Whole frame written.
                        state       <= photon_pkg::DRAW_IDLE;
                    end else begin
                        digit <= digit - 1'b1;
                        state <= photon_pkg::DRAW_REQ;
                    end
                end
                default: state <= photon_pkg::DRAW_IDLE;
            endcase
        end
    end

endmodule

/* hdl/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                 clk_133MHz_210,
    input  logic                 rst_n,
    // Writer side.
    input  photon_pkg::mem_cmd_t wr_cmd,
    output logic                 wr_done,
    // Reader side.
    input  photon_pkg::mem_cmd_t rd_cmd,
    output photon_pkg::mem_rsp_t rd_rsp,
    // Memory side.
    output photon_pkg::mem_cmd_t mem_cmd,
    input  photon_pkg::mem_rsp_t mem_rsp,
    output logic                 mem_busy
);

    photon_pkg::arb_owner_t owner;   // Who holds the memory.

    logic wr_pending;
    logic rd_pending;

    assign wr_pending = wr_cmd.wr;
    assign rd_pending = rd_cmd.rd;

    //////////////////////////////
    // Command and response steering.
    //////////////////////////////
    always_comb begin
        mem_cmd = '0;
        wr_done = 1'b0;
        rd_rsp  = '0;
        case (owner)
            photon_pkg::ARB_IDLE: begin
                // Grant in the cycle seen, write first.
                if (wr_pending) begin
                    mem_cmd = wr_cmd;
                end else if (rd_pending) begin
                    mem_cmd = rd_cmd;
                end
            end
            photon_pkg::ARB_WRITE: begin
                mem_cmd = wr_cmd;          // Client holds it stable.
                wr_done = mem_rsp.done;
            end
            photon_pkg::ARB_READ: begin
                mem_cmd = rd_cmd;
                rd_rsp  = mem_rsp;         // Done and read data.
            end
            default: mem_cmd = '0;
        endcase
    end

    //////////////////////////////
    // Ownership register.
    //////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            owner <= photon_pkg::ARB_IDLE;
        end else begin
            case (owner)
                photon_pkg::ARB_IDLE: begin
                    if (wr_pending)      owner <= photon_pkg::ARB_WRITE;
                    else if (rd_pending) owner <= photon_pkg::ARB_READ;
                end
                // Release the cycle after done.
                default: if (mem_rsp.done) owner <= photon_pkg::ARB_IDLE;
            endcase
        end
    end

    assign mem_busy = (owner != photon_pkg::ARB_IDLE);

endmodule

/* hdl/frame_mem.sv */
`timescale 1ns/1ps

module frame_mem (
    input  logic                 clk_133MHz_210,
    input  logic                 rst_n,
    input  photon_pkg::mem_cmd_t mem_cmd,
    output photon_pkg::mem_rsp_t mem_rsp
);

    logic [photon_pkg::DATA_W-1:0] mem [photon_pkg::MEM_DEPTH];

    logic                           busy;      // Access in flight.
    logic [photon_pkg::LAT_W-1:0]   lat_cnt;   // Cycles since sampling.
    photon_pkg::mem_cmd_t           cmd_q;     // Sampled command.
    logic [photon_pkg::MEM_IDX_W-1:0] idx;
    logic                           last;      // Final latency cycle.

    assign idx  = cmd_q.addr[photon_pkg::MEM_IDX_W-1:0];   // Low bits only.
    assign last = busy && (lat_cnt == photon_pkg::LAT_LAST);

    //////////////////////////////
    // Latency sequencer.
    //////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            lat_cnt <= '0;
        end else if (!busy) begin
            if (mem_cmd.rd || mem_cmd.wr) begin
                busy    <= 1'b1;     // Accept.
                lat_cnt <= '0;
            end
        end else if (last) begin
            busy <= 1'b0;            // Idle again next cycle.
        end else begin
            lat_cnt <= lat_cnt + 1'b1;
        end
    end

    // Storage and command capture.
    always_ff @(posedge clk_133MHz_210) begin
        if (!busy) cmd_q <= mem_cmd;
        if (last && cmd_q.wr) mem[idx] <= cmd_q.data;   // Write lands with done.
    end

    assign mem_rsp.done = last;
    assign mem_rsp.data = mem[idx];   // Valid while done is high.

endmodule

/* hdl/display_reader.sv */
`timescale 1ns/1ps

module display_reader (
    input  logic                          clk_133MHz_210,
    input  logic                          rst_n,
    input  logic                          frame_ready,   // Start a scan.
    output photon_pkg::mem_cmd_t          rd_cmd,
    input  photon_pkg::mem_rsp_t          rd_rsp,
    output logic                          lcd_wr,        // One-cycle strobe.
    output logic [photon_pkg::DATA_W-1:0] lcd_data
);

    photon_pkg::read_state_t state;

    logic [photon_pkg::WORD_IDX_W-1:0] idx;      // Word within frame.
    logic                              rescan;   // Frame landed mid-scan.

    //////////////////////////////
    // Read request.
    //////////////////////////////
    always_comb begin
        rd_cmd      = '0;
        rd_cmd.rd   = (state == photon_pkg::RD_REQ);
        rd_cmd.addr = photon_pkg::FRAME_BASE
                    + {{(photon_pkg::ADDR_W - photon_pkg::WORD_IDX_W){1'b0}}, idx};
    end

    //////////////////////////////
    // Scan FSM.
    //////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state  <= photon_pkg::RD_IDLE;
            idx    <= '0;
            rescan <= 1'b0;
            lcd_wr <= 1'b0;
        end else begin
            lcd_wr <= 1'b0;
            if (frame_ready && (state != photon_pkg::RD_IDLE)) rescan <= 1'b1;
            case (state)
                photon_pkg::RD_IDLE: begin
                    if (frame_ready || rescan) begin
                        rescan <= 1'b0;
                        idx    <= '0;     // Address order.
                        state  <= photon_pkg::RD_REQ;
                    end
                end
                photon_pkg::RD_REQ: begin
                    if (rd_rsp.done) begin
                        lcd_wr <= 1'b1;   // Show the word just read.
                        state  <= photon_pkg::RD_SHOW;
                    end
                end
                photon_pkg::RD_SHOW: begin
                    if (idx == photon_pkg::LAST_WORD) begin
                        state <= photon_pkg::RD_IDLE;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= photon_pkg::RD_REQ;
                    end
                end
                default: state <= photon_pkg::RD_IDLE;
            endcase
        end
    end

    // Display data, captured with the done.
    always_ff @(posedge clk_133MHz_210) begin
        if ((state == photon_pkg::RD_REQ) && rd_rsp.done) lcd_data <= rd_rsp.data;
    end

endmodule

/* hdl/photon_counter_top.sv */
`timescale 1ns/1ps

module photon_counter_top (
    input  logic                          clk_133MHz_210,
    input  logic                          rst_n,
    input  logic                          photon_pulse,   // Photon detector pin.
    input  logic                          sync_50Hz,      // External sync pin.
    output logic                          lcd_wr,
    output logic [photon_pkg::DATA_W-1:0] lcd_data,
    output logic                          mem_busy
);

    //////////////////////////////
    // Internal nets.
    //////////////////////////////
    logic                           count_update;
    logic [photon_pkg::COUNT_W-1:0] count;
    logic                           frame_ready;
    photon_pkg::mem_cmd_t           wr_cmd;    // Writer to arbiter.
    logic                           wr_done;
    photon_pkg::mem_cmd_t           rd_cmd;    // Reader to arbiter.
    photon_pkg::mem_rsp_t           rd_rsp;
    photon_pkg::mem_cmd_t           mem_cmd;   // Arbiter to memory.
    photon_pkg::mem_rsp_t           mem_rsp;

    // Count photons per sync period.
    pulse_counter pulse_counter_inst (
        .clk_133MHz_210, .rst_n, .photon_pulse, .sync_50Hz, .count_update, .count
    );

    // Render the count into frame memory.
    draw_writer draw_writer_inst (
        .clk_133MHz_210, .rst_n, .count_update, .count, .wr_cmd, .wr_done, .frame_ready
    );

    // One memory port, writes first.
    mem_arbiter mem_arbiter_inst (
        .clk_133MHz_210, .rst_n, .wr_cmd, .wr_done, .rd_cmd, .rd_rsp,
        .mem_cmd, .mem_rsp, .mem_busy
    );

    frame_mem frame_mem_inst (
        .clk_133MHz_210, .rst_n, .mem_cmd, .mem_rsp
    );

    // Push the frame out to the display.
    display_reader display_reader_inst (
        .clk_133MHz_210, .rst_n, .frame_ready, .rd_cmd, .rd_rsp, .lcd_wr, .lcd_data
    );

endmodule

/* test/photon_checker.sv */
`timescale 1ns/1ps

module photon_checker (
    input  logic                          clk_133MHz_210,
    input  logic                          rst_n,
    input  logic                          lcd_wr,
    input  logic [photon_pkg::DATA_W-1:0] lcd_data,
    input  logic                          mem_busy
);

    localparam int FRAME_W = photon_pkg::FRAME_WORDS * photon_pkg::DATA_W;

    string              exp_names [$];    // One entry per sync period.
    logic [31:0]        exp_counts [$];
    logic [FRAME_W-1:0] got = '0;         // Frame being collected, first word on top.
    int                 got_n = 0;
    int                 frames_done = 0;
    int                 rows_passed = 0;
    int                 error_count = 0;
    logic               busy_seen = 1'b0; // Arbiter owned a transfer at least once.

    // Character word for one hex digit; digit 0 is the leftmost.
    function automatic logic [15:0] char_word(input logic [31:0] value, input int digit);
        logic [3:0] nib;
        nib = value[4*(7-digit) +: 4];
        if (nib < 4'd10) begin
            char_word = 16'h0030 + {12'h000, nib};          // '0' to '9'.
        end else begin
            char_word = 16'h0041 + {12'h000, nib - 4'd10};  // 'A' to 'F'.
        end
    endfunction

    function automatic logic [FRAME_W-1:0] frame_words(input logic [31:0] value);
        logic [FRAME_W-1:0] w;
        w = '0;
        for (int d = 0; d < photon_pkg::FRAME_WORDS; d++) begin
            w = {w[FRAME_W-photon_pkg::DATA_W-1:0], char_word(value, d)};
        end
        return w;
    endfunction

    //////////////////////////////
    // Hooks for the testbench.
    //////////////////////////////
    task automatic expect_frame(input string name, input logic [31:0] count);
        exp_names.push_back(name);
        exp_counts.push_back(count);
    endtask

    task automatic confirm_busy_low(input string when_txt);
        if (mem_busy !== 1'b0) begin
            $display("mem_busy was not low %s", when_txt);
            error_count++;
        end
    endtask

    task automatic final_drain_check();
        if (got_n != 0) begin
            $display("Display stopped after %0d words of a frame", got_n);
            error_count++;
        end
        if (exp_names.size() != 0) begin
            $display("%0d expected frames never reached the display", exp_names.size());
            error_count++;
        end
        if (!busy_seen) begin
            $display("mem_busy never went high while frames were moved");
            error_count++;
        end
        confirm_busy_low("after the last frame");
    endtask

    //////////////////////////////
    // Frame compare.
    //////////////////////////////
    task automatic compare_frame();
        string              name;
        logic [31:0]        count;
        logic [FRAME_W-1:0] exp;
        name  = exp_names.pop_front();
        count = exp_counts.pop_front();
        exp   = frame_words(count);
        if (got === exp) begin
            $display("[OK] %s: count %0d", name, count);
            rows_passed++;
        end else begin
            $display("[ERROR] %s: expected %h actual %h", name, exp, got);
            error_count++;
        end
        got_n = 0;
        frames_done++;
    endtask

    // Display port, sampled mid-cycle.
    always @(negedge clk_133MHz_210) begin
        if (rst_n && lcd_wr) begin
            if (exp_names.size() == 0) begin
                $display("lcd_wr pulsed with no frame expected, word %h", lcd_data);
                error_count++;
            end else begin
                got = {got[FRAME_W-photon_pkg::DATA_W-1:0], lcd_data};
                got_n++;
                if (got_n == photon_pkg::FRAME_WORDS) compare_frame();
            end
        end
    end

    // Memory traffic shows up on mem_busy.
    always @(negedge clk_133MHz_210) begin
        if (rst_n && mem_busy) busy_seen <= 1'b1;
    end

endmodule

/* test/tb_photon_counter.sv */
`timescale 1ns/1ps

module tb_photon_counter;

    localparam int NUM_ROWS    = 12;
    localparam int FIXED_ROWS  = 6;
    localparam int SYNC_HIGH   = 4;     // Sync pin high time.
    localparam int PRE_SYNC    = 2;     // Quiet cycles before the sync edge.
    localparam int FRAME_ALLOW = photon_pkg::FRAME_WORDS * (photon_pkg::MEM_LATENCY + 4);
    localparam int SETTLE      = 3 * FRAME_ALLOW;   // Quiet time after the last frame.

    logic                          clk_133MHz_210;
    logic                          rst_n;
    logic                          photon_pulse;
    logic                          sync_50Hz;
    logic                          lcd_wr;
    logic [photon_pkg::DATA_W-1:0] lcd_data;
    logic                          mem_busy;

    //////////////////////////////
    // Stimulus table.
    //////////////////////////////
    string row_name   [NUM_ROWS];
    int    row_pulses [NUM_ROWS];
    int    row_high   [NUM_ROWS];   // Pulse high width, cycles.
    int    row_gap    [NUM_ROWS];   // Low time after each pulse.
    int    row_expect [NUM_ROWS];   // Count the frame must show.

    integer seed = 32'h3052_384a;
    int     cycle_count = 0;
    int     timeout_limit = 0;

    always #5 clk_133MHz_210 = ~clk_133MHz_210;

    photon_counter_top photon_counter_top_inst (
        .clk_133MHz_210, .rst_n, .photon_pulse, .sync_50Hz, .lcd_wr, .lcd_data, .mem_busy
    );

    photon_checker photon_checker_inst (
        .clk_133MHz_210, .rst_n, .lcd_wr, .lcd_data, .mem_busy
    );

    task automatic set_row(input int r, input string name, input int pulses,
                           input int high, input int gap, input int expected);
        row_name[r]   = name;
        row_pulses[r] = pulses;
        row_high[r]   = high;
        row_gap[r]    = gap;
        row_expect[r] = expected;
    endtask

    task automatic drive_pulse(input int high, input int gap);
        photon_pulse <= 1'b1;
        repeat (high) @(posedge clk_133MHz_210);
        photon_pulse <= 1'b0;
        repeat (gap) @(posedge clk_133MHz_210);
    endtask

    // Close the period, then wait until its frame has been shown.
    task automatic send_sync(input string name, input int expected);
        int target;
        target = photon_checker_inst.frames_done + 1;
        repeat (PRE_SYNC) @(posedge clk_133MHz_210);
        sync_50Hz <= 1'b1;
        photon_checker_inst.expect_frame(name, expected);
        repeat (SYNC_HIGH) @(posedge clk_133MHz_210);
        sync_50Hz <= 1'b0;
        while (photon_checker_inst.frames_done < target) @(posedge clk_133MHz_210);
    endtask

    // Run limit.
    always @(posedge clk_133MHz_210) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        int n;
        clk_133MHz_210 = 1'b0;
        rst_n          = 1'b0;
        photon_pulse   = 1'b0;
        sync_50Hz      = 1'b0;
        set_row(0, "one", 1, 1, 1, 1);
        set_row(1, "five", 5, 2, 2, 5);
        set_row(2, "thirty_seven", 37, 1, 3, 37);
        set_row(3, "two_fifty_five", 255, 1, 1, 255);
        set_row(4, "zero", 0, 1, 1, 0);
        set_row(5, "wide_pulse", 1, 40, 2, 1);      // One edge only.
        for (int r = FIXED_ROWS; r < NUM_ROWS; r++) begin
            n = $unsigned($random(seed)) % 301;
            set_row(r, $sformatf("random_%0d", r - FIXED_ROWS), n,
                    1 + $unsigned($random(seed)) % 3, 1 + $unsigned($random(seed)) % 4, n);
        end
        timeout_limit = 16 + SETTLE;                // Reset and final wait.
        for (int r = 0; r < NUM_ROWS; r++) begin
            timeout_limit += row_pulses[r] * (row_high[r] + row_gap[r])
                           + PRE_SYNC + SYNC_HIGH + 4 * FRAME_ALLOW;
        end

        repeat (8) @(posedge clk_133MHz_210);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk_133MHz_210);
        photon_checker_inst.confirm_busy_low("after reset");

        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int p = 0; p < row_pulses[r]; p++) drive_pulse(row_high[r], row_gap[r]);
            send_sync(row_name[r], row_expect[r]);
        end

        while (photon_checker_inst.frames_done < NUM_ROWS) @(posedge clk_133MHz_210);
        repeat (SETTLE) @(posedge clk_133MHz_210);  // Room for stray strobes.
        photon_checker_inst.final_drain_check();

        $display("Rows checked: %0d, passed: %0d, errors: %0d", photon_checker_inst.frames_done,
                 photon_checker_inst.rows_passed, photon_checker_inst.error_count);
        if (photon_checker_inst.error_count == 0
                && photon_checker_inst.rows_passed == NUM_ROWS) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* sim.f */
hdl/photon_pkg.sv
hdl/pulse_counter.sv
hdl/draw_writer.sv
hdl/mem_arbiter.sv
hdl/frame_mem.sv
hdl/display_reader.sv
hdl/photon_counter_top.sv
test/photon_checker.sv
test/tb_photon_counter.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the photon counter testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f \
    --top-module tb_photon_counter -o tb_photon_counter

./obj_dir/tb_photon_counter | tee sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    exit 0
else
    exit 1
fi
